// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    // supported opcode groups
    localparam opcode_t OP_R_TYPE   = 7'b0110011;
    localparam opcode_t OP_I_TYPE   = 7'b0010011;
    localparam opcode_t OP_I_TYPE_L = 7'b0000011;  // lw
    localparam opcode_t OP_S_TYPE   = 7'b0100011;  // sw
    localparam opcode_t OP_B_TYPE   = 7'b1100011;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // sub, sra, srai

endpackage

// ==== logic/rv_ctrl_pkg.sv ====
package rv_ctrl_pkg;

    typedef enum logic [1:0] {
        SRC_A_NONE,
        SRC_A_PC,
        SRC_A_OLD_PC,
        SRC_A_REG_1
    } alu_src_a_e;

    typedef enum logic [1:0] {
        SRC_B_NONE,
        SRC_B_REG_2,
        SRC_B_EXT_IMM,
        SRC_B_FOUR
    } alu_src_b_e;

    typedef enum logic [1:0] {
        RES_ALU_OUT,
        RES_ALU_RESULT,
        RES_MEM
    } res_src_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_ITYPE,
        IMM_ITYPE_SHAMT,
        IMM_STYPE,
        IMM_BTYPE
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_NONE
    } alu_op_e;

    typedef struct packed {
        logic neg;
        logic zero;
        logic cout;
        logic ov;
    } alu_flags_s;

    typedef struct packed {
        logic       rf_we;
        logic       m_we;
        alu_src_a_e alu_src_a;
        alu_src_b_e alu_src_b;
        res_src_e   res_src;
        imm_src_e   imm_src;
        alu_op_e    alu_ctrl;
        logic       en_ir;
        logic       en_npc_r;    // pc load
        logic       m_addr_src;  // 0 pc, 1 alu_out
    } ctrl_s;

    typedef struct packed {
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::reg_idx_t rd;
        logic                 rd_we;
        rv_isa_pkg::word_t    rd_value;
    } retire_s;

    localparam int MEM_WORDS = 256;
    typedef logic [$clog2(MEM_WORDS)-1:0] mem_addr_t;

endpackage

// ==== logic/rv_alu_dec.sv ====
module rv_alu_dec (
    input  rv_isa_pkg::opcode_t  op,
    input  logic [2:0]           funct3,
    input  logic [6:0]           funct7,
    output rv_ctrl_pkg::alu_op_e alu_op
);
    logic alt;

    assign alt = (funct7 == rv_isa_pkg::F7_ALT);

    always_comb begin
        alu_op = rv_ctrl_pkg::ALU_NONE;
        case (op)
            rv_isa_pkg::OP_R_TYPE,
            rv_isa_pkg::OP_I_TYPE: begin
                case (funct3)
                    rv_isa_pkg::F3_ADD_SUB: begin
                        // addi has no sub form
                        alu_op = (op == rv_isa_pkg::OP_R_TYPE && alt)
                               ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
                    end
                    rv_isa_pkg::F3_SLL:     alu_op = rv_ctrl_pkg::ALU_SLL;
                    rv_isa_pkg::F3_SLT:     alu_op = rv_ctrl_pkg::ALU_SLT;
                    rv_isa_pkg::F3_SLTU:    alu_op = rv_ctrl_pkg::ALU_SLTU;
                    rv_isa_pkg::F3_XOR:     alu_op = rv_ctrl_pkg::ALU_XOR;
                    rv_isa_pkg::F3_SRL_SRA: begin
                        alu_op = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
                    end
                    rv_isa_pkg::F3_OR:      alu_op = rv_ctrl_pkg::ALU_OR;
                    default:                alu_op = rv_ctrl_pkg::ALU_AND;
                endcase
            end
            rv_isa_pkg::OP_I_TYPE_L,
            rv_isa_pkg::OP_S_TYPE:   alu_op = rv_ctrl_pkg::ALU_ADD;
            rv_isa_pkg::OP_B_TYPE:   alu_op = rv_ctrl_pkg::ALU_SUB;  // compare
            default:                 alu_op = rv_ctrl_pkg::ALU_NONE;
        endcase
    end

endmodule

// ==== logic/rv_alu.sv ====
module rv_alu (
    input  rv_isa_pkg::word_t       a,
    input  rv_isa_pkg::word_t       b,
    input  rv_ctrl_pkg::alu_op_e    op,
    output rv_isa_pkg::word_t       result,
    output rv_ctrl_pkg::alu_flags_s flags
);
    rv_isa_pkg::word_t diff;
    logic              cout;

    // a - b as a + ~b + 1, cout high when a >= b unsigned
    assign {cout, diff} = {1'b0, a} + {1'b0, ~b} + 33'd1;

    assign flags.neg  = diff[31];
    assign flags.zero = (diff == '0);
    assign flags.cout = cout;
    assign flags.ov   = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb begin
        case (op)
            rv_ctrl_pkg::ALU_ADD:  result = a + b;
            rv_ctrl_pkg::ALU_SUB:  result = diff;
            rv_ctrl_pkg::ALU_AND:  result = a & b;
            rv_ctrl_pkg::ALU_OR:   result = a | b;
            rv_ctrl_pkg::ALU_XOR:  result = a ^ b;
            rv_ctrl_pkg::ALU_SLT:  result = {31'd0, flags.neg ^ flags.ov};
            rv_ctrl_pkg::ALU_SLTU: result = {31'd0, !cout};
            rv_ctrl_pkg::ALU_SLL:  result = a << b[4:0];
            rv_ctrl_pkg::ALU_SRL:  result = a >> b[4:0];
            rv_ctrl_pkg::ALU_SRA:  result = $signed(a) >>> b[4:0];
            default:               result = '0;
        endcase
    end

endmodule

// ==== logic/rv_regfile.sv ====
module rv_regfile (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_isa_pkg::reg_idx_t ra1,
    input  rv_isa_pkg::reg_idx_t ra2,
    input  rv_isa_pkg::reg_idx_t wa,
    input  logic                 we,
    input  rv_isa_pkg::word_t    wd,
    output rv_isa_pkg::word_t    rd1,
    output rv_isa_pkg::word_t    rd2
);
    rv_isa_pkg::word_t regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin  // x0 never written
            regs[wa] <= wd;
        end
    end

    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];

endmodule

// ==== logic/rv_controller.sv ====
module rv_controller (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_isa_pkg::word_t      instr,
    input  rv_ctrl_pkg::alu_flags_s alu_flags,
    output rv_ctrl_pkg::ctrl_s     ctrl,
    output logic                   retire_valid,
    output logic                   trap
);
    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        EXEC,
        ALU_W_RF,
        MEM_ADDR,
        MEM_READ,
        MEM_W_RF,
        MEM_WRITE,
        BRANCH,
        ERROR
    } state_e;

    state_e                state;
    state_e                state_nxt;
    rv_isa_pkg::opcode_t   op;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv_ctrl_pkg::alu_op_e  dec_op;
    rv_ctrl_pkg::imm_src_e exec_imm;
    logic                  signed_lt;
    logic                  take_branch;

    assign op     = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    rv_alu_dec u_alu_dec (
        .op     (op),
        .funct3 (funct3),
        .funct7 (funct7),
        .alu_op (dec_op)
    );

    always_comb begin
        case (state)
            FETCH:    state_nxt = DECODE;
            DECODE: begin
                case (op)
                    rv_isa_pkg::OP_R_TYPE,
                    rv_isa_pkg::OP_I_TYPE:   state_nxt = EXEC;
                    rv_isa_pkg::OP_I_TYPE_L,
                    rv_isa_pkg::OP_S_TYPE:   state_nxt = MEM_ADDR;
                    rv_isa_pkg::OP_B_TYPE:   state_nxt = BRANCH;
                    default:                 state_nxt = ERROR;
                endcase
            end
            EXEC:     state_nxt = ALU_W_RF;
            MEM_ADDR: state_nxt = (op == rv_isa_pkg::OP_I_TYPE_L) ? MEM_READ : MEM_WRITE;
            MEM_READ: state_nxt = MEM_W_RF;
            ALU_W_RF,
            MEM_W_RF,
            MEM_WRITE,
            BRANCH:   state_nxt = FETCH;
            default:  state_nxt = ERROR;  // sticky until reset
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_nxt;
        end
    end

    // compare results from rs1 - rs2
    assign signed_lt = alu_flags.neg ^ alu_flags.ov;

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ:  take_branch = alu_flags.zero;
            rv_isa_pkg::F3_BNE:  take_branch = !alu_flags.zero;
            rv_isa_pkg::F3_BLT:  take_branch = signed_lt;
            rv_isa_pkg::F3_BGE:  take_branch = !signed_lt;
            rv_isa_pkg::F3_BLTU: take_branch = !alu_flags.cout;
            rv_isa_pkg::F3_BGEU: take_branch = alu_flags.cout;
            default:             take_branch = 1'b0;
        endcase
    end

    // shift immediates carry only shamt
    assign exec_imm = (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SRL_SRA)
                    ? rv_ctrl_pkg::IMM_ITYPE_SHAMT : rv_ctrl_pkg::IMM_ITYPE;

    always_comb begin
        ctrl.rf_we      = 1'b0;
        ctrl.m_we       = 1'b0;
        ctrl.alu_src_a  = rv_ctrl_pkg::SRC_A_NONE;
        ctrl.alu_src_b  = rv_ctrl_pkg::SRC_B_NONE;
        ctrl.res_src    = rv_ctrl_pkg::RES_ALU_OUT;
        ctrl.imm_src    = rv_ctrl_pkg::IMM_NONE;
        ctrl.alu_ctrl   = rv_ctrl_pkg::ALU_NONE;
        ctrl.en_ir      = 1'b0;
        ctrl.en_npc_r   = 1'b0;
        ctrl.m_addr_src = 1'b0;
        case (state)
            FETCH: begin
                ctrl.en_ir     = 1'b1;
                ctrl.en_npc_r  = 1'b1;
                ctrl.alu_src_a = rv_ctrl_pkg::SRC_A_PC;
                ctrl.alu_src_b = rv_ctrl_pkg::SRC_B_FOUR;
                ctrl.alu_ctrl  = rv_ctrl_pkg::ALU_ADD;
                ctrl.res_src   = rv_ctrl_pkg::RES_ALU_RESULT;  // pc + 4
            end
            DECODE: begin
                ctrl.alu_src_a = rv_ctrl_pkg::SRC_A_OLD_PC;  // branch target
                ctrl.alu_src_b = rv_ctrl_pkg::SRC_B_EXT_IMM;
                ctrl.imm_src   = rv_ctrl_pkg::IMM_BTYPE;
                ctrl.alu_ctrl  = rv_ctrl_pkg::ALU_ADD;
            end
            EXEC: begin
                ctrl.alu_src_a = rv_ctrl_pkg::SRC_A_REG_1;
                ctrl.alu_src_b = (op == rv_isa_pkg::OP_R_TYPE)
                               ? rv_ctrl_pkg::SRC_B_REG_2 : rv_ctrl_pkg::SRC_B_EXT_IMM;
                ctrl.imm_src   = exec_imm;
                ctrl.alu_ctrl  = dec_op;
            end
            ALU_W_RF: begin
                ctrl.rf_we = 1'b1;
            end
            MEM_ADDR: begin
                ctrl.alu_src_a = rv_ctrl_pkg::SRC_A_REG_1;
                ctrl.alu_src_b = rv_ctrl_pkg::SRC_B_EXT_IMM;
                ctrl.imm_src   = (op == rv_isa_pkg::OP_I_TYPE_L)
                               ? rv_ctrl_pkg::IMM_ITYPE : rv_ctrl_pkg::IMM_STYPE;
                ctrl.alu_ctrl  = rv_ctrl_pkg::ALU_ADD;
            end
            MEM_READ: begin
                ctrl.m_addr_src = 1'b1;
            end
            MEM_WRITE: begin
                ctrl.m_we       = 1'b1;
                ctrl.m_addr_src = 1'b1;
            end
            MEM_W_RF: begin
                ctrl.rf_we   = 1'b1;
                ctrl.res_src = rv_ctrl_pkg::RES_MEM;
            end
            BRANCH: begin
                ctrl.alu_src_a = rv_ctrl_pkg::SRC_A_REG_1;
                ctrl.alu_src_b = rv_ctrl_pkg::SRC_B_REG_2;
                ctrl.alu_ctrl  = dec_op;
                ctrl.en_npc_r  = take_branch;  // pc <= alu_out
            end
            default: begin
            end
        endcase
    end

    assign retire_valid = state inside {ALU_W_RF, MEM_W_RF, MEM_WRITE, BRANCH};
    assign trap         = (state == ERROR);

    assert property (@(posedge clk) disable iff (rst) !(ctrl.rf_we && ctrl.m_we))
        else $error("register and memory write in the same cycle");

endmodule

// ==== logic/rv_datapath.sv ====
module rv_datapath (
    input  logic                    clk,
    input  logic                    rst,
    input  rv_ctrl_pkg::ctrl_s      ctrl,
    output rv_isa_pkg::word_t       instr,
    output rv_ctrl_pkg::alu_flags_s alu_flags,
    output rv_ctrl_pkg::mem_addr_t  mem_addr,
    output rv_isa_pkg::word_t       mem_wdata,
    input  rv_isa_pkg::word_t       mem_rdata,
    output rv_ctrl_pkg::retire_s    retire
);
    localparam int AW = $bits(rv_ctrl_pkg::mem_addr_t);

    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::word_t    old_pc;
    rv_isa_pkg::word_t    ir;
    rv_isa_pkg::word_t    reg_a;
    rv_isa_pkg::word_t    reg_b;
    rv_isa_pkg::word_t    alu_out;
    rv_isa_pkg::word_t    mdr;
    rv_isa_pkg::word_t    rd1;
    rv_isa_pkg::word_t    rd2;
    rv_isa_pkg::word_t    imm_ext;
    rv_isa_pkg::word_t    src_a;
    rv_isa_pkg::word_t    src_b;
    rv_isa_pkg::word_t    alu_result;
    rv_isa_pkg::word_t    result;
    rv_isa_pkg::reg_idx_t rd;

    assign rd = ir[11:7];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.en_npc_r) begin
            pc <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.en_ir) begin
            ir     <= mem_rdata;
            old_pc <= pc;  // address of the fetched word
        end
        reg_a   <= rd1;
        reg_b   <= rd2;
        alu_out <= alu_result;
        mdr     <= mem_rdata;
    end

    rv_regfile u_regfile (
        .clk (clk),
        .rst (rst),
        .ra1 (ir[19:15]),
        .ra2 (ir[24:20]),
        .wa  (rd),
        .we  (ctrl.rf_we),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    always_comb begin
        case (ctrl.imm_src)
            rv_ctrl_pkg::IMM_ITYPE:       imm_ext = {{20{ir[31]}}, ir[31:20]};
            rv_ctrl_pkg::IMM_ITYPE_SHAMT: imm_ext = {27'd0, ir[24:20]};
            rv_ctrl_pkg::IMM_STYPE:       imm_ext = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            rv_ctrl_pkg::IMM_BTYPE: begin
                imm_ext = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            default:                      imm_ext = '0;
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_a)
            rv_ctrl_pkg::SRC_A_PC:     src_a = pc;
            rv_ctrl_pkg::SRC_A_OLD_PC: src_a = old_pc;
            rv_ctrl_pkg::SRC_A_REG_1:  src_a = reg_a;
            default:                   src_a = '0;
        endcase
        case (ctrl.alu_src_b)
            rv_ctrl_pkg::SRC_B_REG_2:   src_b = reg_b;
            rv_ctrl_pkg::SRC_B_EXT_IMM: src_b = imm_ext;
            rv_ctrl_pkg::SRC_B_FOUR:    src_b = 32'd4;
            default:                    src_b = '0;
        endcase
    end

    rv_alu u_alu (
        .a      (src_a),
        .b      (src_b),
        .op     (ctrl.alu_ctrl),
        .result (alu_result),
        .flags  (alu_flags)
    );

    always_comb begin
        case (ctrl.res_src)
            rv_ctrl_pkg::RES_ALU_RESULT: result = alu_result;
            rv_ctrl_pkg::RES_MEM:        result = mdr;
            default:                     result = alu_out;
        endcase
    end

    // byte address to word index
    assign mem_addr  = ctrl.m_addr_src ? alu_out[AW+1:2] : pc[AW+1:2];
    assign mem_wdata = reg_b;
    assign instr     = ir;

    assign retire = '{pc: old_pc, rd: rd, rd_we: ctrl.rf_we, rd_value: result};

endmodule

// ==== logic/rv_mem.sv ====
module rv_mem (
    input  logic                   clk,
    input  logic                   we,
    input  rv_ctrl_pkg::mem_addr_t addr,
    input  rv_isa_pkg::word_t      wdata,
    output rv_isa_pkg::word_t      rdata,
    input  logic                   load_en,
    input  rv_ctrl_pkg::mem_addr_t load_addr,
    input  rv_isa_pkg::word_t      load_data
);
    rv_isa_pkg::word_t mem [rv_ctrl_pkg::MEM_WORDS];

    always_ff @(posedge clk) begin
        if (load_en) begin  // program load wins
            mem[load_addr] <= load_data;
        end else if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

    // loads arrive only under reset, when the controller keeps m_we low
    assert property (@(posedge clk) load_en |-> !we)
        else $error("core store while loading program");

endmodule

// ==== logic/rv_core.sv ====
module rv_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load_en,
    input  rv_ctrl_pkg::mem_addr_t load_addr,
    input  rv_isa_pkg::word_t      load_data,
    output logic                   retire_valid,
    output rv_ctrl_pkg::retire_s   retire,
    output logic                   trap
);
    rv_ctrl_pkg::ctrl_s      ctrl;
    rv_ctrl_pkg::alu_flags_s alu_flags;
    rv_isa_pkg::word_t       instr;
    rv_ctrl_pkg::mem_addr_t  mem_addr;
    rv_isa_pkg::word_t       mem_wdata;
    rv_isa_pkg::word_t       mem_rdata;

    rv_controller u_controller (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .alu_flags    (alu_flags),
        .ctrl         (ctrl),
        .retire_valid (retire_valid),
        .trap         (trap)
    );

    rv_datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .instr     (instr),
        .alu_flags (alu_flags),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .retire    (retire)
    );

    rv_mem u_mem (
        .clk       (clk),
        .we        (ctrl.m_we),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// ==== bench/tb_rv_core.sv ====
module tb_rv_core;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int PROG_WORDS      = RESET_CYCLES;  // one load per reset cycle
    localparam int HOLD_CYCLES     = 20;
    localparam int ROUNDS          = 40;
    localparam int WATCHDOG_CYCLES = ROUNDS * (RESET_CYCLES + HOLD_CYCLES + 6 * PROG_WORDS) + 100;
    localparam rv_isa_pkg::word_t ILLEGAL_WORD = 32'h0000_007f;  // opcode 1111111
    localparam logic [2:0] F3_WORD = 3'b010;

    typedef struct packed {
        rv_ctrl_pkg::retire_s rec;
        int unsigned          cycles;  // strobe distance to the previous retire
    } expect_s;

    logic                   clk;
    logic                   rst;
    logic                   load_en;
    rv_ctrl_pkg::mem_addr_t load_addr;
    rv_isa_pkg::word_t      load_data;
    logic                   retire_valid;
    rv_ctrl_pkg::retire_s   retire;
    logic                   trap;

    rv_isa_pkg::word_t prog [PROG_WORDS];
    rv_isa_pkg::word_t model_regs [32];
    rv_isa_pkg::word_t model_mem [rv_ctrl_pkg::MEM_WORDS];
    expect_s           expected [$];
    int                prog_len;
    int                r_count;
    int                i_count;
    int                b_count;
    rv_isa_pkg::word_t rng_state;
    int unsigned       cycle_count;
    int unsigned       last_retire;
    logic              trap_seen;

    rv_core u_rv_core (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .retire_valid (retire_valid),
        .retire       (retire),
        .trap         (trap)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic rv_isa_pkg::word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic rv_isa_pkg::reg_idx_t pick_reg();
        rv_isa_pkg::word_t r;
        r = next_rand();
        return {2'b00, r[2:0]};  // x0..x7
    endfunction

    function automatic rv_isa_pkg::word_t model_alu(input logic [2:0] f3, input logic alt,
                                                   input rv_isa_pkg::word_t a,
                                                   input rv_isa_pkg::word_t b);
        rv_isa_pkg::word_t y;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: y = alt ? a - b : a + b;
            rv_isa_pkg::F3_SLL:     y = a << b[4:0];
            rv_isa_pkg::F3_SLT:     y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            rv_isa_pkg::F3_SLTU:    y = (a < b) ? 32'd1 : 32'd0;
            rv_isa_pkg::F3_XOR:     y = a ^ b;
            rv_isa_pkg::F3_SRL_SRA: begin
                if (alt) begin
                    y = $signed(a) >>> b[4:0];
                end else begin
                    y = a >> b[4:0];
                end
            end
            rv_isa_pkg::F3_OR:      y = a | b;
            default:                y = a & b;
        endcase
        return y;
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input rv_isa_pkg::word_t a,
                                          input rv_isa_pkg::word_t b);
        case (f3)
            rv_isa_pkg::F3_BEQ:  return a == b;
            rv_isa_pkg::F3_BNE:  return a != b;
            rv_isa_pkg::F3_BLT:  return $signed(a) < $signed(b);
            rv_isa_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            rv_isa_pkg::F3_BLTU: return a < b;
            default:             return a >= b;
        endcase
    endfunction

    task automatic expect_retire(input rv_isa_pkg::reg_idx_t rd, input logic we,
                                 input rv_isa_pkg::word_t value, input int unsigned cycles);
        expect_s e;
        e.rec.pc       = rv_isa_pkg::word_t'(prog_len * 4);
        e.rec.rd       = rd;
        e.rec.rd_we    = we;
        e.rec.rd_value = value;
        e.cycles       = cycles;
        expected.push_back(e);
        if (we && rd != 5'd0) begin
            model_regs[rd] = value;
        end
        prog_len++;
    endtask

    task automatic place_addi(input rv_isa_pkg::reg_idx_t rd, input logic [11:0] imm,
                              input logic retires);
        prog[prog_len] = {imm, 5'd0, rv_isa_pkg::F3_ADD_SUB, rd, rv_isa_pkg::OP_I_TYPE};
        if (retires) begin
            expect_retire(rd, 1'b1, {{20{imm[11]}}, imm}, 4);
        end else begin
            prog_len++;  // skipped by a taken branch
        end
    endtask

    task automatic add_reg_op(input int idx);
        logic [2:0]           f3;
        logic                 alt;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        alt = (idx >= 8);  // 8 sub, 9 sra
        f3  = (idx == 9) ? rv_isa_pkg::F3_SRL_SRA : (idx == 8) ? rv_isa_pkg::F3_ADD_SUB : idx[2:0];
        rd  = pick_reg();
        rs1 = pick_reg();
        rs2 = pick_reg();
        prog[prog_len] = {alt ? rv_isa_pkg::F7_ALT : 7'd0, rs2, rs1, f3, rd,
                          rv_isa_pkg::OP_R_TYPE};
        expect_retire(rd, 1'b1, model_alu(f3, alt, model_regs[rs1], model_regs[rs2]), 4);
    endtask

    task automatic add_imm_op(input int idx);
        logic [2:0]           f3;
        logic                 alt;
        logic [11:0]          imm;
        rv_isa_pkg::word_t    r;
        rv_isa_pkg::word_t    b;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::reg_idx_t rs1;
        alt = (idx == 8);  // srai
        f3  = alt ? rv_isa_pkg::F3_SRL_SRA : idx[2:0];
        r   = next_rand();
        rd  = pick_reg();
        rs1 = pick_reg();
        if (f3 == rv_isa_pkg::F3_SLL || f3 == rv_isa_pkg::F3_SRL_SRA) begin
            imm = {alt ? rv_isa_pkg::F7_ALT : 7'd0, r[24:20]};
            b   = {27'd0, r[24:20]};
        end else begin
            imm = r[31:20];
            b   = {{20{imm[11]}}, imm};
        end
        prog[prog_len] = {imm, rs1, f3, rd, rv_isa_pkg::OP_I_TYPE};
        expect_retire(rd, 1'b1, model_alu(f3, alt, model_regs[rs1], b), 4);
    endtask

    task automatic add_store_load();
        rv_isa_pkg::word_t      r;
        rv_ctrl_pkg::mem_addr_t slot;
        logic [11:0]            imm;
        rv_isa_pkg::reg_idx_t   rs2;
        rv_isa_pkg::reg_idx_t   rd;
        r    = next_rand();
        slot = {2'b11, r[5:0]};  // data words above the program
        imm  = {2'b00, slot, 2'b00};
        rs2  = pick_reg();
        rd   = pick_reg();
        prog[prog_len] = {imm[11:5], rs2, 5'd0, F3_WORD, imm[4:0], rv_isa_pkg::OP_S_TYPE};
        model_mem[slot] = model_regs[rs2];
        expect_retire(5'd0, 1'b0, '0, 4);
        prog[prog_len] = {imm, 5'd0, F3_WORD, rd, rv_isa_pkg::OP_I_TYPE_L};
        expect_retire(rd, 1'b1, model_mem[slot], 5);
    endtask

    task automatic add_branch(input int idx);
        logic [2:0]           f3;
        rv_isa_pkg::word_t    r;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        logic                 taken;
        f3    = (idx < 2) ? idx[2:0] : idx[2:0] + 3'd2;
        rs1   = pick_reg();
        r     = next_rand();
        rs2   = (r[1:0] == 2'd0) ? rs1 : pick_reg();  // equal operands now and then
        taken = model_branch(f3, model_regs[rs1], model_regs[rs2]);
        // offset +8 jumps over one addi
        prog[prog_len] = {1'b0, 6'd0, rs2, rs1, f3, 4'b0100, 1'b0, rv_isa_pkg::OP_B_TYPE};
        expect_retire(5'd0, 1'b0, '0, 3);
        place_addi(rv_isa_pkg::reg_idx_t'(r % 7 + 1), r[31:20], !taken);
    endtask

    task automatic build_program();
        rv_isa_pkg::word_t r;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = ILLEGAL_WORD;
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        prog_len = 0;
        expected.delete();
        for (int i = 0; i < 3; i++) begin
            r = next_rand();
            place_addi(rv_isa_pkg::reg_idx_t'(r % 7 + 1), r[31:20], 1'b1);
        end
        while (prog_len < PROG_WORDS - 2) begin  // last word stays illegal
            r = next_rand();
            case (r[1:0])
                2'd0: begin
                    add_reg_op(r_count % 10);
                    r_count++;
                end
                2'd1: begin
                    add_imm_op(i_count % 9);
                    i_count++;
                end
                2'd2: add_store_load();
                default: begin
                    add_branch(b_count % 6);
                    b_count++;
                end
            endcase
        end
    endtask

    task automatic load_program();
        @(negedge clk);
        rst = 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            load_en   = 1'b1;
            load_addr = rv_ctrl_pkg::mem_addr_t'(i);
            load_data = prog[i];
            @(negedge clk);
        end
        assert (!retire_valid && !trap) else report_mismatch("retire or trap active in reset");
        load_en = 1'b0;
        rst     = 1'b0;
    endtask

    task automatic check_retire();
        expect_s     want;
        int unsigned gap;
        assert (expected.size() > 0) else report_mismatch("retire with no instruction expected");
        want = expected.pop_front();
        gap  = cycle_count - last_retire;
        assert (retire.pc == want.rec.pc)
            else report_mismatch($sformatf("retire pc %h, expected %h", retire.pc, want.rec.pc));
        assert (retire.rd_we == want.rec.rd_we)
            else report_mismatch($sformatf("rd_we %b at pc %h", retire.rd_we, retire.pc));
        if (want.rec.rd_we) begin
            assert (retire.rd == want.rec.rd)
                else report_mismatch($sformatf("rd x%0d, expected x%0d", retire.rd, want.rec.rd));
            assert (retire.rd_value == want.rec.rd_value)
                else report_mismatch($sformatf("pc %h value %h, expected %h", retire.pc,
                                               retire.rd_value, want.rec.rd_value));
        end
        assert (gap == want.cycles)
            else report_mismatch($sformatf("pc %h took %0d cycles, expected %0d", retire.pc,
                                           gap, want.cycles));
        last_retire = cycle_count;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (rst) begin
            last_retire = cycle_count;  // first fetch starts after this edge
            trap_seen   = 1'b0;
        end else if (retire_valid) begin
            check_retire();
        end else if (trap && !trap_seen) begin
            trap_seen = 1'b1;
            assert (expected.size() == 0) else report_mismatch("trap before all retires");
            assert (cycle_count - last_retire == 3)
                else report_mismatch("trap not raised right after decode of the illegal word");
        end
    end

    assert property (@(posedge clk) disable iff (rst) trap |-> !retire_valid)
        else report_mismatch("retire strobe while trapped");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired before the last program reached its trap");
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        rng_state   = 32'd97081;
        cycle_count = 0;
        last_retire = 0;
        trap_seen   = 1'b0;
        r_count     = 0;
        i_count     = 0;
        b_count     = 0;
        for (int round = 0; round < ROUNDS; round++) begin
            build_program();
            load_program();
            @(posedge clk);
            while (!trap) begin
                @(posedge clk);
            end
            repeat (HOLD_CYCLES) begin
                @(posedge clk);
                assert (trap) else report_mismatch("trap dropped before reset");
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/rv_alu_dec.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_controller.sv
logic/rv_datapath.sv
logic/rv_mem.sv
logic/rv_core.sv
bench/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module tb_rv_core -f flist.f -o tb_rv_core \
    && ./obj_dir/tb_rv_core \
    || { echo "simulation did not pass"; exit 1; }
